// File: include/bus_bridge_defines.svh
// Bridge size macros: bus widths, FIFO depths and pin frame length
`ifndef BUS_BRIDGE_DEFINES_SVH
`define BUS_BRIDGE_DEFINES_SVH

// Core-side word bus
`define BB_ADDR_W 32 // Address width
`define BB_DATA_W 32 // Data width

// Request FIFO depth, also the producer's starting credit count
`define BB_REQ_DEPTH 4

// Response FIFO depth, also the serializer's starting response credits
`define BB_RSP_DEPTH 2

// Pin frame
// Cycles 1-4 address/data bytes, 5 direction byte, 6-9 read bytes
`define BB_FRAME_LEN 9

// Pin bus byte width
`define BB_PIN_W 8

`endif

// File: source/bus_bridge_pkg.sv
// Bridge types: core request, read response and output pin bundle
`include "bus_bridge_defines.svh"

package bus_bridge_pkg;

  // One word request from the core
  typedef struct packed {
    logic [`BB_ADDR_W-1:0] addr;  // Word address
    logic [`BB_DATA_W-1:0] wdata; // Write data, ignored on reads
    logic                  write; // 1 = write, 0 = read
  } bb_req_t;

  // Read response returned to the core
  typedef struct packed {
    logic [`BB_DATA_W-1:0] rdata; // Assembled read word
  } bb_rsp_t;

  // Everything the bridge drives toward the device pins
  typedef struct packed {
    logic [`BB_PIN_W-1:0] addr_byte; // Address byte, direction byte in cycle 5
    logic [`BB_PIN_W-1:0] data_byte; // Write data byte
    logic                 oe;        // Data pins driven by the bridge
    logic                 sync;      // Frame start strobe, cycle 1 only
  } bb_pins_out_t;

endpackage

// File: source/req_issue.sv
// Request producer: core valid/ready handshake and request-link credit counter
`timescale 1ns/100ps
`include "bus_bridge_defines.svh"

module req_issue
  import bus_bridge_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  // Core request port
  input  logic    req_valid,
  input  bb_req_t req,
  output logic    req_ready,
  // Credit link toward the request FIFO
  input  logic    credit_return,
  output logic    push,
  output bb_req_t push_data
);

  localparam int DEPTH = `BB_REQ_DEPTH;
  localparam int CW    = $clog2(DEPTH + 1);

  logic [CW-1:0] credits; // Free slots in the request FIFO
  logic          accept;

  // Ready only while a slot is known to be free downstream
  assign req_ready = (credits != '0);
  assign accept    = req_valid & req_ready;

  // An accepted request is written into the FIFO on the same edge,
  // so the handshake itself is the push
  assign push      = accept;
  assign push_data = req;

  // Spend one on each push, get one back on each returned pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= CW'(DEPTH);
    end else begin
      credits <= credits - CW'(accept) + CW'(credit_return);
    end
  end

  // FIFO must never hand back more credits than it has slots
  a_credit_bound: assert property (
    @(posedge clk) disable iff (rst)
    credits <= CW'(DEPTH)
  ) else $error("req_issue: credit count above request FIFO depth");

  // A returned credit implies an earlier push that consumed it
  a_return_has_push: assert property (
    @(posedge clk) disable iff (rst)
    credit_return |-> (credits < CW'(DEPTH)) || push
  ) else $error("req_issue: credit returned with no request outstanding");

endmodule

// File: source/credit_fifo.sv
// Circular FIFO buffer with a type-parameterized payload and one credit pulse per pop
`timescale 1ns/100ps

module credit_fifo
  import bus_bridge_pkg::*;
#(
  parameter type payload_t = bb_rsp_t,
  parameter int  DEPTH     = 2
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t head,
  output logic     not_empty,
  output logic     credit_return
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  payload_t      mem [DEPTH]; // Entry storage
  logic [AW-1:0] wptr;
  logic [AW-1:0] rptr;
  logic [CW-1:0] count;       // Entries held
  logic          full;
  logic          wr_en;
  logic          rd_en;

  assign full      = (count == CW'(DEPTH));
  assign not_empty = (count != '0);
  assign head      = mem[rptr];       // Show-ahead head entry
  assign wr_en     = push & ~full;
  assign rd_en     = pop & not_empty;

  // Storage holds payload only
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wptr          <= '0;
      rptr          <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      if (wr_en) begin
        wptr <= (wptr == AW'(DEPTH - 1)) ? '0 : wptr + 1'b1; // Wrap at depth
      end
      if (rd_en) begin
        rptr <= (rptr == AW'(DEPTH - 1)) ? '0 : rptr + 1'b1;
      end
      count         <= count + CW'(wr_en) - CW'(rd_en);
      credit_return <= rd_en; // Slot freed, tell the sender next cycle
    end
  end

  // Sender's credit count must keep it from overrunning the buffer
  a_no_push_full: assert property (
    @(posedge clk) disable iff (rst)
    push |-> !full
  ) else $error("credit_fifo: push while full");

  // Consumer only pops what it was shown
  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (rst)
    pop |-> not_empty
  ) else $error("credit_fifo: pop while empty");

endmodule

// File: source/pin_serializer.sv
// Pin serializer: 9-cycle byte frame, read word assembly and response credit counter
`timescale 1ns/100ps
`include "bus_bridge_defines.svh"

module pin_serializer
  import bus_bridge_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  // Request FIFO head
  input  logic                 req_avail,
  input  bb_req_t              req_head,
  output logic                 req_pop,
  // Device pins
  output bb_pins_out_t         pins,
  input  logic [`BB_PIN_W-1:0] bus_din,
  // Credit link toward the response FIFO
  output logic                 rsp_push,
  output bb_rsp_t              rsp_data,
  input  logic                 rsp_credit_return
);

  localparam int FRAME_LEN = `BB_FRAME_LEN;
  localparam int CNT_W     = $clog2(FRAME_LEN + 1);
  localparam int RSP_DEPTH = `BB_RSP_DEPTH;
  localparam int CW        = $clog2(RSP_DEPTH + 1);

  logic [CNT_W-1:0] cnt;         // Frame cycle, 0 when idle
  bb_req_t          cur;         // Request being framed
  logic [23:0]      rdata_q;     // Read bytes 0-2
  logic [CW-1:0]    rsp_credits; // Free slots in the response FIFO
  logic             idle;
  logic             frame_end;
  logic             rsp_room;
  logic             can_start;

  assign idle      = (cnt == '0);
  assign frame_end = (cnt == CNT_W'(FRAME_LEN));

  // Last cycle of a read hands its word over
  assign rsp_push       = frame_end & ~cur.write;
  assign rsp_data.rdata = {bus_din, rdata_q}; // Byte 3 comes straight off the pins

  // A read needs a credit left over after any push going out this cycle
  assign rsp_room  = (rsp_credits > CW'(rsp_push));
  assign can_start = (idle | frame_end) & req_avail & (req_head.write | rsp_room);
  assign req_pop   = can_start;

  // Frame counter, restarts at 1 on the last cycle when more work is queued
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= '0;
    end else if (can_start) begin
      cnt <= CNT_W'(1);
    end else if (frame_end) begin
      cnt <= '0;
    end else if (!idle) begin
      cnt <= cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (can_start) begin
      cur <= req_head;
    end
    // Device returns bytes least significant first
    case (cnt)
      CNT_W'(6): rdata_q[7:0]   <= bus_din;
      CNT_W'(7): rdata_q[15:8]  <= bus_din;
      CNT_W'(8): rdata_q[23:16] <= bus_din;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_credits <= CW'(RSP_DEPTH);
    end else begin
      rsp_credits <= rsp_credits - CW'(rsp_push) + CW'(rsp_credit_return);
    end
  end

  // Pin outputs decoded from the frame state
  always_comb begin
    pins      = '0;
    pins.sync = (cnt == CNT_W'(1));
    pins.oe   = ~idle & cur.write; // Drive data pins for the whole write frame
    case (cnt)
      CNT_W'(1): begin
        pins.addr_byte = cur.addr[7:0];
        pins.data_byte = cur.wdata[7:0];
      end
      CNT_W'(2): begin
        pins.addr_byte = cur.addr[15:8];
        pins.data_byte = cur.wdata[15:8];
      end
      CNT_W'(3): begin
        pins.addr_byte = cur.addr[23:16];
        pins.data_byte = cur.wdata[23:16];
      end
      CNT_W'(4): begin
        pins.addr_byte = cur.addr[31:24];
        pins.data_byte = cur.wdata[31:24];
      end
      CNT_W'(5): pins.addr_byte = {7'b0, cur.write}; // Direction byte
      default: ;
    endcase
  end

  // Response FIFO slot must be held before the word is pushed
  a_push_has_credit: assert property (
    @(posedge clk) disable iff (rst)
    rsp_push |-> (rsp_credits != '0)
  ) else $error("pin_serializer: response push without credit");

endmodule

// File: source/bus_bridge_top.sv
// Bridge top level: producer, request FIFO, pin serializer and response FIFO
`timescale 1ns/100ps
`include "bus_bridge_defines.svh"

module bus_bridge_top
  import bus_bridge_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  // Core request port
  input  logic                 req_valid,
  input  bb_req_t              req,
  output logic                 req_ready,
  // Core response port
  output logic                 resp_valid,
  output bb_rsp_t              resp,
  input  logic                 resp_ready,
  // Device pins
  output bb_pins_out_t         pins,
  input  logic [`BB_PIN_W-1:0] bus_din
);

  logic    req_push;
  bb_req_t req_push_data;
  logic    req_credit;
  logic    req_avail;
  bb_req_t req_head;
  logic    req_pop;
  logic    rsp_push;
  bb_rsp_t rsp_data;
  logic    rsp_credit;

  req_issue u_req_issue (
    .clk           (clk),
    .rst           (rst),
    .req_valid     (req_valid),
    .req           (req),
    .req_ready     (req_ready),
    .credit_return (req_credit),
    .push          (req_push),
    .push_data     (req_push_data)
  );

  credit_fifo #(.payload_t(bb_req_t), .DEPTH(`BB_REQ_DEPTH)) u_req_fifo (
    .clk           (clk),
    .rst           (rst),
    .push          (req_push),
    .push_data     (req_push_data),
    .pop           (req_pop),
    .head          (req_head),
    .not_empty     (req_avail),
    .credit_return (req_credit)
  );

  pin_serializer u_pin_serializer (
    .clk               (clk),
    .rst               (rst),
    .req_avail         (req_avail),
    .req_head          (req_head),
    .req_pop           (req_pop),
    .pins              (pins),
    .bus_din           (bus_din),
    .rsp_push          (rsp_push),
    .rsp_data          (rsp_data),
    .rsp_credit_return (rsp_credit)
  );

  // Response FIFO drains on the core's valid/ready handshake
  credit_fifo #(.payload_t(bb_rsp_t), .DEPTH(`BB_RSP_DEPTH)) u_rsp_fifo (
    .clk           (clk),
    .rst           (rst),
    .push          (rsp_push),
    .push_data     (rsp_data),
    .pop           (resp_valid & resp_ready),
    .head          (resp),
    .not_empty     (resp_valid),
    .credit_return (rsp_credit)
  );

endmodule

// File: testbench/tb_bus_bridge.sv
// Bus bridge testbench with clock, device model, scoreboard, directed tests and timeout
`timescale 1ns/100ps
`include "bus_bridge_defines.svh"

module tb_bus_bridge
  import bus_bridge_pkg::*;
();

  localparam int FRAME          = `BB_FRAME_LEN;
  localparam int TIMEOUT_CYCLES = 3000;          // About 50 frames of 9 cycles plus stalls
  localparam int STALL_WIN      = 2 * FRAME + 2; // Longer than any gap while frames still run

  logic         clk;
  logic         rst;
  logic         req_valid;
  bb_req_t      req;
  logic         req_ready;
  logic         resp_valid;
  bb_rsp_t      resp;
  logic         resp_ready;
  bb_pins_out_t pins;
  logic [7:0]   bus_din;

  logic [31:0] sb_mem [logic [31:0]];  // Scoreboard view of device memory
  logic [31:0] dev_mem [logic [31:0]]; // Device model storage
  logic [31:0] exp_q [$];              // Expected read words in request order
  int          cycle_count = 0;
  int          sync_count = 0;
  int          read_count = 0;
  int          rsp_count = 0;
  logic        rand_stall;

  bus_bridge_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk; // 40 ns period
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
      fail_run($sformatf("ERR %s actual=0x%08h expected=0x%08h", name, actual, expected));
  endtask

  task automatic next_cycle();
    @(negedge clk);
    if (rand_stall)
      resp_ready = ($urandom_range(0, 3) != 0); // Ready three cycles in four
  endtask

  // Drive one request at a falling edge and record what the device should see
  task automatic send_req(input logic [31:0] a, input logic [31:0] d, input logic w);
    req.addr  = a;
    req.wdata = d;
    req.write = w;
    req_valid = 1'b1;
    while (!req_ready)
      next_cycle();
    next_cycle(); // Handshake on the rising edge just passed
    req_valid = 1'b0;
    if (w) begin
      sb_mem[a] = d;
    end else begin
      exp_q.push_back(sb_mem.exists(a) ? sb_mem[a] : ~a);
      read_count++;
    end
  endtask

  task automatic wait_responses();
    rand_stall = 1'b0;
    resp_ready = 1'b1;
    while (exp_q.size() != 0)
      next_cycle();
  endtask

  // Device model samples the pins and drives read bytes mid-cycle
  initial begin
    int          cyc;
    logic [31:0] dev_addr;
    logic [31:0] dev_wdata;
    logic [31:0] dev_rword;
    cyc       = 0;
    dev_addr  = '0;
    dev_wdata = '0;
    dev_rword = '0;
    bus_din   = 8'h00;
    forever begin
      @(negedge clk);
      if (pins.sync)
        cyc = 1;
      else if (cyc != 0 && cyc < FRAME)
        cyc++;
      else
        cyc = 0;
      bus_din = 8'h00;
      if (cyc >= 1 && cyc <= 4) begin
        dev_addr[(cyc-1)*8 +: 8]  = pins.addr_byte;
        dev_wdata[(cyc-1)*8 +: 8] = pins.data_byte;
      end else if (cyc == 5) begin
        if (pins.addr_byte[0])
          dev_mem[dev_addr] = dev_wdata;
        else
          dev_rword = dev_mem.exists(dev_addr) ? dev_mem[dev_addr] : ~dev_addr;
      end else if (cyc >= 6) begin
        bus_din = dev_rword[(cyc-6)*8 +: 8]; // Least significant byte first
      end
    end
  end

  // Frame starts, response handshakes and the run limit
  always @(posedge clk) begin
    cycle_count++;
    if (pins.sync)
      sync_count++;
    if (!rst && resp_valid && resp_ready) begin
      if (exp_q.size() == 0) begin
        fail_run("Response arrived with no read outstanding");
      end else begin
        check_value("resp.rdata", resp.rdata, exp_q.pop_front());
        rsp_count++;
      end
    end
    if (cycle_count >= TIMEOUT_CYCLES)
      fail_run("Timeout: tests did not finish within the cycle limit");
  end

  task automatic test_reset_state();
    check_value("req_ready", 32'(req_ready), 32'd1);
    check_value("resp_valid", 32'(resp_valid), 32'd0);
    check_value("pins.sync", 32'(pins.sync), 32'd0);
    check_value("pins.oe", 32'(pins.oe), 32'd0);
  endtask

  task automatic test_single_write();
    logic [31:0] a;
    logic [31:0] d;
    a = $urandom;
    d = $urandom;
    send_req(a, d, 1'b1);
    check_value("pins.sync", 32'(pins.sync), 32'd0); // Request FIFO pop cycle
    next_cycle();
    check_value("pins.sync", 32'(pins.sync), 32'd1);
    for (int k = 0; k < 4; k++) begin
      check_value("pins.addr_byte", 32'(pins.addr_byte), 32'(a[k*8 +: 8]));
      check_value("pins.data_byte", 32'(pins.data_byte), 32'(d[k*8 +: 8]));
      check_value("pins.oe", 32'(pins.oe), 32'd1);
      next_cycle();
    end
    check_value("pins.addr_byte[0]", 32'(pins.addr_byte[0]), 32'd1); // Direction is write
    for (int k = 5; k <= FRAME; k++) begin
      check_value("pins.oe", 32'(pins.oe), 32'd1);
      next_cycle();
    end
    check_value("pins.oe", 32'(pins.oe), 32'd0);
  endtask

  task automatic test_write_read();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] d;
    a = $urandom;
    d = $urandom;
    do b = $urandom; while (sb_mem.exists(b) || b == a); // Address never written
    send_req(a, d, 1'b1);
    send_req(a, 32'h0, 1'b0);
    send_req(b, 32'h0, 1'b0);
    wait_responses();
  endtask

  // Fill both FIFOs with reads until the bridge stops accepting
  task automatic test_credit_exhaust();
    int low_run;
    int base_syncs;
    int base_reads;
    low_run    = 0;
    base_syncs = sync_count;
    base_reads = read_count;
    resp_ready = 1'b0;
    while (low_run < STALL_WIN) begin
      if (req_ready) begin
        send_req($urandom, 32'h0, 1'b0);
        low_run = 0;
      end else begin
        next_cycle();
        low_run++;
      end
    end
    check_value("reads accepted", 32'(read_count - base_reads),
                32'(`BB_RSP_DEPTH + `BB_REQ_DEPTH));
    check_value("read frames", 32'(sync_count - base_syncs), 32'(`BB_RSP_DEPTH));
    check_value("resp_valid", 32'(resp_valid), 32'd1);
    wait_responses();
    next_cycle();
    check_value("req_ready", 32'(req_ready), 32'd1);
  endtask

  task automatic test_random_mix();
    logic [31:0] a;
    logic [31:0] d;
    logic        w;
    rand_stall = 1'b1;
    for (int i = 0; i < 40; i++) begin
      a = 32'h2000_0000 | {26'b0, 4'($urandom_range(0, 15)), 2'b00}; // Small pool for hits
      d = $urandom;
      w = 1'($urandom_range(0, 1));
      send_req(a, d, w);
    end
    wait_responses();
  endtask

  initial begin
    void'($urandom(32'h6de0_b095)); // Seed once for the whole run
    rst        = 1'b1;
    req_valid  = 1'b0;
    req        = '0;
    resp_ready = 1'b1;
    rand_stall = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_reset_state();
    test_single_write();
    test_write_read();
    test_credit_exhaust();
    test_random_mix();
    if (rsp_count != read_count) begin
      fail_run("Number of responses does not match number of reads issued");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

// File: project.f
+incdir+include
source/bus_bridge_pkg.sv
source/req_issue.sv
source/credit_fifo.sv
source/pin_serializer.sv
source/bus_bridge_top.sv
testbench/tb_bus_bridge.sv

// File: run.sh
#!/bin/sh
# Build the bus bridge testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_bus_bridge \
  -f project.f \
  -o sim_bus_bridge

# Exit status is nonzero when the testbench stops with $fatal
./obj_dir/sim_bus_bridge
